//--- Makefile
# Verilator build and run for the AXI read-path ID width converter

VERILATOR ?= verilator
TOP       ?= tb_iwc
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "Simulation did not report a pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/ar_id_mapper.sv
// AR channel path of the ID width converter.
// Looks the incoming subordinate ID up in the remap slots, reuses the slot
// that already holds it or takes the lowest idle one, and forwards the AR
// with the slot index as its manager ID. Stalls when no slot can take it.

`timescale 1ns/10ps

`include "iwc_cfg.svh"

module ar_id_mapper (
  input  iwc_pkg::sbr_ar_t          sbr_ar_i,
  input  logic                      sbr_ar_valid_i,
  output logic                      sbr_ar_ready_o,
  output iwc_pkg::mgr_ar_t          mgr_ar_o,
  output logic                      mgr_ar_valid_o,
  input  logic                      mgr_ar_ready_i,
  input  logic [`IWC_NUM_SLOTS-1:0] slot_match_i,
  input  logic [`IWC_NUM_SLOTS-1:0] slot_busy_i,
  input  logic [`IWC_NUM_SLOTS-1:0] slot_full_i,
  output iwc_pkg::sbr_id_t          lookup_id_o,
  output logic [`IWC_NUM_SLOTS-1:0] claim_o
);

  import iwc_pkg::*;

  logic    hit;
  mgr_id_t hit_idx;
  logic    free;
  mgr_id_t free_idx;
  mgr_id_t slot_sel;
  logic    can_go;
  logic    ar_xfer;

  // Every slot compares its stored ID against this one
  assign lookup_id_o = sbr_ar_i.id;

  // At most one slot can match, so the encoder needs no priority
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < `IWC_NUM_SLOTS; i++) begin
      if (slot_match_i[i]) begin
        hit     = 1'b1;
        hit_idx = mgr_id_t'(i);
      end
    end
  end

  // Scanning downwards leaves the lowest idle slot as the final pick
  always_comb begin
    free     = 1'b0;
    free_idx = '0;
    for (int i = `IWC_NUM_SLOTS - 1; i >= 0; i--) begin
      if (!slot_busy_i[i]) begin
        free     = 1'b1;
        free_idx = mgr_id_t'(i);
      end
    end
  end

  // A known ID must stay on its own slot to keep its order
  assign slot_sel = hit ? hit_idx : free_idx;

  // A known ID waits for room on its slot, a new one waits for an idle slot
  assign can_go = hit ? !slot_full_i[hit_idx] : free;

  assign mgr_ar_o.id   = slot_sel;
  assign mgr_ar_o.addr = sbr_ar_i.addr;
  assign mgr_ar_o.len  = sbr_ar_i.len;

  assign mgr_ar_valid_o = sbr_ar_valid_i && can_go;

  // Ready only follows the manager while a request is actually pending
  assign sbr_ar_ready_o = sbr_ar_valid_i && can_go && mgr_ar_ready_i;

  assign ar_xfer = sbr_ar_valid_i && can_go && mgr_ar_ready_i;

  // One claim per accepted AR, on the slot the AR was sent to
  always_comb begin
    claim_o = '0;
    if (ar_xfer) begin
      claim_o[slot_sel] = 1'b1;
    end
  end

  // Two slots holding the same live ID would split its ordering domain
  always_comb begin
    assert final ($onehot0(slot_match_i))
      else $error("[FAIL] slot_match_i=%h lookup_id_o=%h", slot_match_i, lookup_id_o);
  end

endmodule

//--- design/id_slot.sv
// One entry of the ID remap table.
// Remembers the subordinate ID bound to this manager ID and counts its
// bursts in flight. The binding lasts until the count drops back to zero.

`timescale 1ns/10ps

`include "iwc_cfg.svh"

module id_slot (
  input  logic             clk_i,
  input  logic             reset_i,
  input  iwc_pkg::sbr_id_t lookup_id_i,
  input  logic             claim_i,
  input  logic             release_i,
  output logic             match_o,
  output logic             busy_o,
  output logic             full_o,
  output iwc_pkg::sbr_id_t stored_id_o
);

  import iwc_pkg::*;

  sbr_id_t id_q;
  cnt_t    cnt_q;

  // Count of bursts accepted on AR whose last R beat has not passed yet
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (claim_i && !release_i) begin
      cnt_q <= cnt_q + cnt_t'(1);
    end else if (release_i && !claim_i) begin
      cnt_q <= cnt_q - cnt_t'(1);
    end
  end

  // The ID only binds on the first claim; later claims carry the same ID
  always_ff @(posedge clk_i) begin
    if (claim_i && !busy_o) begin
      id_q <= lookup_id_i;
    end
  end

  assign busy_o = (cnt_q != '0);
  assign full_o = (cnt_q == cnt_t'(`IWC_MAX_TXNS_PER_ID));

  // An idle slot never matches, whatever its stale ID register holds
  assign match_o = busy_o && (id_q == lookup_id_i);

  assign stored_id_o = id_q;

  // A last beat on a slot with nothing outstanding means the manager
  // answered a burst this converter never issued on that ID
  assert property (@(posedge clk_i) disable iff (reset_i) release_i |-> busy_o)
    else $error("[FAIL] release_i=%h cnt_q=%h", release_i, cnt_q);

  // The mapper must hold back a burst once the per-ID limit is reached
  assert property (@(posedge clk_i) disable iff (reset_i) claim_i |-> !full_o)
    else $error("[FAIL] claim_i=%h cnt_q=%h", claim_i, cnt_q);

endmodule

//--- design/iwc_cfg.svh
// Configuration constants for the AXI read-path ID width converter.
// Sizes the subordinate and manager ID fields, the AR and R payloads and
// the remap table that links the two ID spaces.

`ifndef IWC_CFG_SVH
`define IWC_CFG_SVH

// Subordinate port IDs are 6 bits wide
`define IWC_SBR_ID_W 6

// Manager port IDs are 2 bits wide and double as the slot index
`define IWC_MGR_ID_W 2

// One slot per manager ID, so this is 2 ** IWC_MGR_ID_W
`define IWC_NUM_SLOTS 4

// Bursts that may be in flight on one slot at the same time
`define IWC_MAX_TXNS_PER_ID 4

// Payload widths shared by both ports
`define IWC_ADDR_W 32
`define IWC_DATA_W 32
`define IWC_LEN_W 8

// Counter must reach IWC_MAX_TXNS_PER_ID without wrapping
`define IWC_CNT_W 3

`endif

//--- design/iwc_pkg.sv
// Shared types for the AXI read-path ID width converter.
// Holds the vector types for IDs, payload fields and slot counters, and the
// packed AR and R channel structs of both ports.

`include "iwc_cfg.svh"

package iwc_pkg;

  // ID of a burst as seen on the subordinate port
  typedef logic [`IWC_SBR_ID_W-1:0] sbr_id_t;

  // ID on the manager port, which is also the index of a remap slot
  typedef logic [`IWC_MGR_ID_W-1:0] mgr_id_t;

  typedef logic [`IWC_ADDR_W-1:0] addr_t;
  typedef logic [`IWC_DATA_W-1:0] data_t;

  // AXI burst length, encoded as beats minus one
  typedef logic [`IWC_LEN_W-1:0] len_t;

  // Number of bursts a slot still has outstanding
  typedef logic [`IWC_CNT_W-1:0] cnt_t;

  // Read address channel on the subordinate port
  typedef struct packed {
    sbr_id_t id;
    addr_t   addr;
    len_t    len;
  } sbr_ar_t;

  // Read address channel on the manager port
  typedef struct packed {
    mgr_id_t id;
    addr_t   addr;
    len_t    len;
  } mgr_ar_t;

  // Read data channel on the subordinate port
  typedef struct packed {
    sbr_id_t id;
    data_t   data;
    logic    last;
  } sbr_r_t;

  // Read data channel on the manager port
  typedef struct packed {
    mgr_id_t id;
    data_t   data;
    logic    last;
  } mgr_r_t;

endpackage

//--- design/iwc_top.sv
// AXI read-path ID width converter, remapping variant.
// Maps each live 6-bit subordinate ID onto one of four 2-bit manager IDs
// so that bursts with equal IDs stay ordered and bursts with different IDs
// stay reorderable. Read data gets its original ID back on the way out.

`timescale 1ns/10ps

`include "iwc_cfg.svh"

module iwc_top (
  input  logic             clk_i,
  input  logic             reset_i,
  // Subordinate port
  input  iwc_pkg::sbr_ar_t sbr_ar_i,
  input  logic             sbr_ar_valid_i,
  output logic             sbr_ar_ready_o,
  output iwc_pkg::sbr_r_t  sbr_r_o,
  output logic             sbr_r_valid_o,
  input  logic             sbr_r_ready_i,
  // Manager port
  output iwc_pkg::mgr_ar_t mgr_ar_o,
  output logic             mgr_ar_valid_o,
  input  logic             mgr_ar_ready_i,
  input  iwc_pkg::mgr_r_t  mgr_r_i,
  input  logic             mgr_r_valid_i,
  output logic             mgr_r_ready_o
);

  import iwc_pkg::*;

  // Per-slot status, one bit per manager ID
  logic [`IWC_NUM_SLOTS-1:0] slot_match;
  logic [`IWC_NUM_SLOTS-1:0] slot_busy;
  logic [`IWC_NUM_SLOTS-1:0] slot_full;

  // One-hot strobes that add or retire one burst on a slot
  logic [`IWC_NUM_SLOTS-1:0] slot_claim;
  logic [`IWC_NUM_SLOTS-1:0] slot_release;

  // Subordinate ID held by every slot, read back on the R path
  sbr_id_t [`IWC_NUM_SLOTS-1:0] slot_id;

  // ID of the pending AR, compared against every slot
  sbr_id_t lookup_id;

  ar_id_mapper u_ar_id_mapper (
    .sbr_ar_i       (sbr_ar_i),
    .sbr_ar_valid_i (sbr_ar_valid_i),
    .sbr_ar_ready_o (sbr_ar_ready_o),
    .mgr_ar_o       (mgr_ar_o),
    .mgr_ar_valid_o (mgr_ar_valid_o),
    .mgr_ar_ready_i (mgr_ar_ready_i),
    .slot_match_i   (slot_match),
    .slot_busy_i    (slot_busy),
    .slot_full_i    (slot_full),
    .lookup_id_o    (lookup_id),
    .claim_o        (slot_claim)
  );

  // The slot index is the manager ID that the slot owns
  for (genvar i = 0; i < `IWC_NUM_SLOTS; i++) begin : gen_slot
    id_slot u_id_slot (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .lookup_id_i (lookup_id),
      .claim_i     (slot_claim[i]),
      .release_i   (slot_release[i]),
      .match_o     (slot_match[i]),
      .busy_o      (slot_busy[i]),
      .full_o      (slot_full[i]),
      .stored_id_o (slot_id[i])
    );
  end

  r_id_restorer u_r_id_restorer (
    .mgr_r_i       (mgr_r_i),
    .mgr_r_valid_i (mgr_r_valid_i),
    .mgr_r_ready_o (mgr_r_ready_o),
    .sbr_r_o       (sbr_r_o),
    .sbr_r_valid_o (sbr_r_valid_o),
    .sbr_r_ready_i (sbr_r_ready_i),
    .slot_id_i     (slot_id),
    .release_o     (slot_release)
  );

endmodule

//--- design/r_id_restorer.sv
// R channel path of the ID width converter.
// Swaps the manager ID of each read beat for the subordinate ID that its
// slot holds and retires one burst from that slot on every last beat.
// Data, last and the handshake pass through without a register stage.

`timescale 1ns/10ps

`include "iwc_cfg.svh"

module r_id_restorer (
  input  iwc_pkg::mgr_r_t                         mgr_r_i,
  input  logic                                    mgr_r_valid_i,
  output logic                                    mgr_r_ready_o,
  output iwc_pkg::sbr_r_t                         sbr_r_o,
  output logic                                    sbr_r_valid_o,
  input  logic                                    sbr_r_ready_i,
  input  iwc_pkg::sbr_id_t [`IWC_NUM_SLOTS-1:0]   slot_id_i,
  output logic [`IWC_NUM_SLOTS-1:0]               release_o
);

  import iwc_pkg::*;

  mgr_id_t r_slot;
  logic    r_xfer;

  // The manager ID of a beat is the index of the slot it belongs to
  assign r_slot = mgr_r_i.id;

  // The slot binding cannot change while its bursts are still open,
  // so the stored ID is valid for every beat the manager returns
  assign sbr_r_o.id   = slot_id_i[r_slot];
  assign sbr_r_o.data = mgr_r_i.data;
  assign sbr_r_o.last = mgr_r_i.last;

  assign sbr_r_valid_o = mgr_r_valid_i;

  // Stalls on the subordinate side hold the manager with no buffering
  assign mgr_r_ready_o = sbr_r_ready_i;

  assign r_xfer = mgr_r_valid_i && sbr_r_ready_i;

  // Only the final beat of a burst hands its credit back to the slot
  always_comb begin
    release_o = '0;
    if (r_xfer && mgr_r_i.last) begin
      release_o[r_slot] = 1'b1;
    end
  end

endmodule

//--- test/tb_iwc.sv
// Testbench for the AXI read-path ID width converter.
// Sends bursts with a handful of subordinate IDs, answers them from a
// manager model that reorders across IDs, and checks the ID mapping,
// the slot stalls, the restored read IDs and R back-pressure.

`timescale 1ns/10ps

`include "iwc_cfg.svh"

module tb_iwc;

  import iwc_pkg::*;

  localparam int accept_limit = 500;
  localparam int drain_limit  = 4000;
  localparam int num_bursts   = 80;

  // Small ID set, more IDs than slots so new IDs stall now and then
  localparam sbr_id_t id_set [8] = '{6'h03, 6'h11, 6'h2a, 6'h08, 6'h3f, 6'h00, 6'h15, 6'h1c};

  logic    clk_i;
  logic    reset_i;
  sbr_ar_t sbr_ar;
  logic    sbr_ar_valid;
  logic    sbr_ar_ready;
  sbr_r_t  sbr_r;
  logic    sbr_r_valid;
  logic    sbr_r_ready;
  mgr_ar_t mgr_ar;
  logic    mgr_ar_valid;
  logic    mgr_ar_ready;
  mgr_r_t  mgr_r;
  logic    mgr_r_valid;
  logic    mgr_r_ready;

  // Reference state, updated by the monitor on rising edges
  int      inflight [1 << `IWC_SBR_ID_W];
  mgr_id_t slot_of_id [1 << `IWC_SBR_ID_W];
  int      slot_cnt [`IWC_NUM_SLOTS];
  sbr_id_t id_of_addr [addr_t];
  len_t    len_of_addr [addr_t];
  len_t    next_beat [addr_t];

  // Handoff from the monitor to the manager model
  logic    ar_taken;
  mgr_ar_t ar_taken_req;
  logic    r_taken;

  // Set by the stimulus on rising edges, read by the manager model
  logic    r_enable;
  logic    random_ready;

  addr_t       next_addr;
  logic [31:0] lfsr_q = 32'h19c74150;

  // Bursts the manager still owes, one queue per manager ID
  mgr_ar_t rsp_q [`IWC_NUM_SLOTS][$];

  // Galois LFSR with one shift for every bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      if (lfsr_q[0]) begin
        lfsr_q = (lfsr_q >> 1) ^ 32'h80200003;
      end else begin
        lfsr_q = lfsr_q >> 1;
      end
    end
    return v;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  iwc_top u_iwc_top (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .sbr_ar_i       (sbr_ar),
    .sbr_ar_valid_i (sbr_ar_valid),
    .sbr_ar_ready_o (sbr_ar_ready),
    .sbr_r_o        (sbr_r),
    .sbr_r_valid_o  (sbr_r_valid),
    .sbr_r_ready_i  (sbr_r_ready),
    .mgr_ar_o       (mgr_ar),
    .mgr_ar_valid_o (mgr_ar_valid),
    .mgr_ar_ready_i (mgr_ar_ready),
    .mgr_r_i        (mgr_r),
    .mgr_r_valid_i  (mgr_r_valid),
    .mgr_r_ready_o  (mgr_r_ready)
  );

  // A stalled read beat must hold its ID, data and last
  assert property (@(posedge clk_i) disable iff (reset_i)
                   sbr_r_valid && !sbr_r_ready |=> sbr_r_valid && $stable(sbr_r))
    else fail_now($sformatf("[FAIL] sbr_r=%h sbr_r_valid=%h changed while stalled",
                            sbr_r, sbr_r_valid));

  always @(posedge clk_i) begin : monitor
    sbr_id_t sid;
    mgr_id_t exp_slot;
    logic    can_go;
    addr_t   base;
    len_t    beat;
    sbr_id_t rid;
    sid      = sbr_ar.id;
    exp_slot = '0;
    can_go   = 1'b0;
    ar_taken = 1'b0;
    if (!reset_i) begin
      // A live ID keeps its slot, a new ID gets the lowest idle slot
      if (inflight[sid] > 0) begin
        exp_slot = slot_of_id[sid];
        can_go   = (inflight[sid] < `IWC_MAX_TXNS_PER_ID);
      end else begin
        for (int m = 0; m < `IWC_NUM_SLOTS; m++) begin
          if (!can_go && slot_cnt[m] == 0) begin
            exp_slot = mgr_id_t'(m);
            can_go   = 1'b1;
          end
        end
      end
      if (sbr_ar_valid) begin
        assert (mgr_ar_valid == can_go)
          else fail_now($sformatf("[FAIL] mgr_ar_valid got %h expected %h", mgr_ar_valid, can_go));
        assert (sbr_ar_ready == (can_go && mgr_ar_ready))
          else fail_now($sformatf("[FAIL] sbr_ar_ready got %h expected %h",
                                  sbr_ar_ready, can_go && mgr_ar_ready));
        if (mgr_ar_valid) begin
          assert (mgr_ar.addr == sbr_ar.addr)
            else fail_now($sformatf("[FAIL] mgr_ar.addr got %h expected %h",
                                    mgr_ar.addr, sbr_ar.addr));
          assert (mgr_ar.len == sbr_ar.len)
            else fail_now($sformatf("[FAIL] mgr_ar.len got %h expected %h",
                                    mgr_ar.len, sbr_ar.len));
          assert (int'(mgr_ar.id) < `IWC_NUM_SLOTS && mgr_ar.id == exp_slot)
            else fail_now($sformatf("[FAIL] mgr_ar.id got %h expected %h", mgr_ar.id, exp_slot));
        end
      end else begin
        assert (!mgr_ar_valid && !sbr_ar_ready)
          else fail_now("AR valid or ready was raised with no request pending");
      end

      // R passes straight through apart from the restored ID
      assert (sbr_r_valid == mgr_r_valid)
        else fail_now($sformatf("[FAIL] sbr_r_valid got %h expected %h", sbr_r_valid, mgr_r_valid));
      assert (mgr_r_ready == sbr_r_ready)
        else fail_now($sformatf("[FAIL] mgr_r_ready got %h expected %h", mgr_r_ready, sbr_r_ready));
      if (sbr_r_valid) begin
        // Data is the burst address plus the beat index
        base = {sbr_r.data[`IWC_DATA_W-1:8], 8'h00};
        beat = sbr_r.data[7:0];
        assert (id_of_addr.exists(base))
          else fail_now("read data encodes an address that was never requested");
        assert (sbr_r.id == id_of_addr[base])
          else fail_now($sformatf("[FAIL] sbr_r.id got %h expected %h", sbr_r.id, id_of_addr[base]));
        assert (sbr_r.data == mgr_r.data)
          else fail_now($sformatf("[FAIL] sbr_r.data got %h expected %h", sbr_r.data, mgr_r.data));
        assert (beat == next_beat[base])
          else fail_now($sformatf("[FAIL] sbr_r.data got %h expected %h",
                                  sbr_r.data, base + data_t'(next_beat[base])));
        assert (sbr_r.last == mgr_r.last && sbr_r.last == (beat == len_of_addr[base]))
          else fail_now($sformatf("[FAIL] sbr_r.last got %h expected %h",
                                  sbr_r.last, beat == len_of_addr[base]));
        if (sbr_r_ready) begin
          rid = id_of_addr[base];
          next_beat[base] = beat + len_t'(1);
          if (sbr_r.last) begin
            inflight[rid]--;
            slot_cnt[slot_of_id[rid]]--;
          end
        end
      end

      // Claims are booked after releases, as the slot counter does
      if (mgr_ar_valid && mgr_ar_ready) begin
        inflight[sid]++;
        slot_of_id[sid] = mgr_ar.id;
        slot_cnt[mgr_ar.id]++;
        id_of_addr[sbr_ar.addr]  = sid;
        len_of_addr[sbr_ar.addr] = sbr_ar.len;
        next_beat[sbr_ar.addr]   = '0;
        ar_taken     = 1'b1;
        ar_taken_req = mgr_ar;
      end
    end
    r_taken = !reset_i && mgr_r_valid && mgr_r_ready;
  end

  // Manager model, answers whole bursts in random order across IDs
  initial begin : manager_model
    mgr_ar_t burst;
    len_t    beat;
    logic    active;
    mgr_id_t pick;
    mgr_id_t slot;
    sbr_r_ready  = 1'b0;
    mgr_ar_ready = 1'b0;
    mgr_r        = '0;
    mgr_r_valid  = 1'b0;
    burst        = '0;
    beat         = '0;
    active       = 1'b0;
    forever begin
      @(negedge clk_i);
      if (ar_taken) begin
        rsp_q[ar_taken_req.id].push_back(ar_taken_req);
      end
      if (mgr_r_valid && r_taken) begin
        if (mgr_r.last) begin
          active = 1'b0;
        end else begin
          beat = beat + len_t'(1);
        end
      end
      if (!active && r_enable) begin
        pick = mgr_id_t'(rand_bits(2));
        for (int k = 0; k < `IWC_NUM_SLOTS; k++) begin
          slot = pick + mgr_id_t'(k);
          if (!active && rsp_q[slot].size() > 0) begin
            burst  = rsp_q[slot].pop_front();
            beat   = '0;
            active = 1'b1;
          end
        end
      end
      mgr_r_valid = active;
      mgr_r.id    = burst.id;
      mgr_r.data  = burst.addr + data_t'(beat);
      mgr_r.last  = (beat == burst.len);
      if (random_ready) begin
        sbr_r_ready  = (rand_bits(2) != 0);
        mgr_ar_ready = (rand_bits(2) != 0);
      end else begin
        sbr_r_ready  = 1'b1;
        mgr_ar_ready = 1'b1;
      end
    end
  end

  task automatic drive_ar(input sbr_id_t id, input len_t len);
    sbr_ar.id    = id;
    sbr_ar.addr  = next_addr;
    sbr_ar.len   = len;
    sbr_ar_valid = 1'b1;
    next_addr    = next_addr + 32'h100;
  endtask

  task automatic wait_accept(input string what);
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (!(sbr_ar_valid && sbr_ar_ready)) begin
      waited++;
      if (waited > accept_limit) begin
        fail_now($sformatf("timeout: %s was never accepted", what));
      end
      @(posedge clk_i);
    end
  endtask

  task automatic send_ar(input sbr_id_t id, input len_t len, input int gap);
    @(negedge clk_i);
    sbr_ar_valid = 1'b0;
    repeat (gap) @(negedge clk_i);
    drive_ar(id, len);
    wait_accept("AR");
  endtask

  // Holds an AR that must stall, then lets the manager retire bursts
  task automatic expect_stall(input sbr_id_t id);
    @(negedge clk_i);
    drive_ar(id, len_t'(0));
    repeat (8) begin
      @(posedge clk_i);
      assert (!sbr_ar_ready)
        else fail_now($sformatf("[FAIL] sbr_ar_ready got %h expected %h", sbr_ar_ready, 1'b0));
    end
    r_enable = 1'b1;
    wait_accept("stalled AR");
  endtask

  task automatic drain();
    int waited;
    int total;
    waited = 0;
    total  = 1;
    @(negedge clk_i);
    sbr_ar_valid = 1'b0;
    while (total != 0) begin
      @(negedge clk_i);
      total = 0;
      for (int m = 0; m < `IWC_NUM_SLOTS; m++) begin
        total += slot_cnt[m];
      end
      waited++;
      if (waited > drain_limit) begin
        fail_now("timeout: outstanding bursts never completed");
      end
    end
    @(posedge clk_i);
  endtask

  initial begin : stimulus
    sbr_id_t id;
    len_t    len;
    reset_i      = 1'b1;
    sbr_ar       = '0;
    sbr_ar_valid = 1'b0;
    r_enable     = 1'b0;
    random_ready = 1'b0;
    next_addr    = 32'h4000_0000;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(posedge clk_i);
    assert (!mgr_ar_valid && !sbr_r_valid)
      else fail_now($sformatf("[FAIL] mgr_ar_valid=%h sbr_r_valid=%h after reset",
                              mgr_ar_valid, sbr_r_valid));

    // Mixed traffic with random ready patterns and reordered responses
    r_enable     = 1'b1;
    random_ready = 1'b1;
    for (int n = 0; n < num_bursts; n++) begin
      id  = id_set[3'(rand_bits(3))];
      len = len_t'(rand_bits(2));
      send_ar(id, len, int'(rand_bits(1)));
    end
    drain();

    // Four distinct IDs take every slot, so a fifth one waits
    random_ready = 1'b0;
    r_enable     = 1'b0;
    for (int k = 0; k < `IWC_NUM_SLOTS; k++) begin
      send_ar(id_set[k], len_t'(k), 0);
    end
    expect_stall(id_set[`IWC_NUM_SLOTS]);
    drain();

    // One ID at its burst limit holds back its next burst
    r_enable = 1'b0;
    for (int k = 0; k < `IWC_MAX_TXNS_PER_ID; k++) begin
      send_ar(id_set[5], len_t'(1), 0);
    end
    expect_stall(id_set[5]);
    drain();

    $display("sim passed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+design
design/iwc_pkg.sv
design/id_slot.sv
design/ar_id_mapper.sv
design/r_id_restorer.sv
design/iwc_top.sv
test/tb_iwc.sv
